// File: compile.f
hdl/corr_pkg.sv
hdl/corr_sequencer.sv
hdl/corr_pair_select.sv
hdl/corr_accumulate.sv
hdl/vis_axil_reader.sv
hdl/corr_top.sv
tb/corr_assertions.sv
tb/corr_tb.sv

// File: Bender.yml
package:
  name: vis_corr

sources:
  - files:
      - hdl/corr_pkg.sv
      - hdl/corr_sequencer.sv
      - hdl/corr_pair_select.sv
      - hdl/corr_accumulate.sv
      - hdl/vis_axil_reader.sv
      - hdl/corr_top.sv
  - target: test
    files:
      - tb/corr_assertions.sv
      - tb/corr_tb.sv

// File: tb/corr_testdata.txt
# S re im sw      one sample, real bits and imaginary bits per antenna, bank switch flag
# V pair cos sin  expected counts of the last finished integration, all fields hex
S 00 ff 1
S ff ff 0
S 0f 00 0
S 5a 3c 0
S c3 96 1
V 0 3 2
V 1 4 1
V 2 3 1
V 3 3 2
V 4 4 2
V 5 3 1
V 6 3 3
V 7 4 2
V 8 3 2
V 9 3 3
V a 4 3
V b 3 2
S ff 00 0
S 00 00 0
V 0 3 2
V 4 4 2
V a 4 3
S aa 55 1
V 0 3 2
V 1 2 2
V 2 2 1
V 3 2 2
V 4 2 1
V 5 3 2
V 6 3 2
V 7 2 2
V 8 2 1
V 9 2 2
V a 2 1
V b 3 2

// File: tb/corr_tb.sv
`timescale 1ns/10ps
`default_nettype none

module corr_tb import corr_pkg::*; ();

   localparam int         NUM_PAIRS = 12;  // Default of corr_top
   localparam logic [1:0] OKAY      = 2'b00;
   localparam logic [1:0] SLVERR    = 2'b10;

   // One line of the data file
   typedef struct packed {
      logic [7:0]        kind;             // S or V
      sample_t           smp;
      logic [SLOT_W-1:0] pair;
      vis_t              vis;
   } rec_t;

   logic clk_x, rst_n, smp_valid, smp_ready;
   sample_t smp;
   logic [7:0] awaddr, araddr;
   logic [31:0] wdata, rdata;
   logic [3:0] wstrb;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [1:0] bresp, rresp;

   rec_t recs[$];                          // Whole data file
   vis_t last_vis [NUM_PAIRS];             // Latest expected value per pair
   int   cycles, limit;
   logic pending;                          // Slots of a sample still in flight

   corr_top dut_i (.*);

   initial begin
      clk_x = 1'b0;
      forever #50 clk_x = ~clk_x;
   end

   // Failed assertions in both bound checkers
   function automatic int assert_errors();
      return dut_i.axil_i.axil_chk_i.err_cnt + dut_i.seq_i.seq_chk_i.err_cnt;
   endfunction

   // --------------------------------------------------
   // Watchdog and assertion monitor
   // --------------------------------------------------
   always @(posedge clk_x) begin
      cycles <= cycles + 1;
      if (assert_errors() != 0) begin
         $display("A protocol assertion on the DUT failed before %0t", $time);
         $display("TEST FAILED");
         $fatal(1, "Assertion failure");
      end else if (limit > 0 && cycles >= limit) begin
         $display("Simulation timed out after %0d cycles", cycles);
         $display("TEST FAILED");
         $fatal(1, "Cycle limit reached");
      end
   end

   task automatic fail_check(input string msg);
      $display("** Error at %0t: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "Stopped at first mismatch");
   endtask

   task automatic check_vis(input vis_word_u got, input vis_word_u exp, input string what);
      if (got.raw !== exp.raw) begin
         fail_check($sformatf("%s: got cos %0d sin %0d, expected cos %0d sin %0d", what,
            got.vis.cos_cnt, got.vis.sin_cnt, exp.vis.cos_cnt, exp.vis.sin_cnt));
      end
   endtask

   task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
      if (got !== exp) begin
         fail_check($sformatf("%s: got response %b, expected %b", what, got, exp));
      end
   endtask

   task automatic load_testdata();
      int fd, code, a, b, c;
      logic [7:0] tag;
      logic [8*100-1:0] skip_line;
      rec_t rec;
      fd = $fopen("tb/corr_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test data file tb/corr_testdata.txt");
         $display("TEST FAILED");
         $fatal(1, "No test data");
      end
      code = $fscanf(fd, " %c", tag);
      while (code == 1) begin
         if (tag == "#") begin
            code = $fgets(skip_line, fd);   // Column description
         end else begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            if (code != 3 || (tag != "S" && tag != "V")) begin
               $display("The test data file holds a line that cannot be read");
               $display("TEST FAILED");
               $fatal(1, "Bad test data");
            end
            rec = '0;
            rec.kind = tag;
            rec.smp  = '{re: a[7:0], im: b[7:0], sw: c[0]};
            rec.pair = a[SLOT_W-1:0];
            rec.vis  = '{sin_cnt: c[ACC_W-1:0], cos_cnt: b[ACC_W-1:0]};
            recs.push_back(rec);
         end
         code = $fscanf(fd, " %c", tag);
      end
      $fclose(fd);
   endtask

   // --------------------------------------------------
   // Bus and sample drivers entered on a falling edge
   // --------------------------------------------------
   task automatic send_sample(input sample_t s);
      repeat ($urandom_range(2, 0)) @(negedge clk_x);   // Idle gap
      smp = s;
      smp_valid = 1'b1;
      while (!smp_ready) @(negedge clk_x);
      @(negedge clk_x);                    // Taken on the rising edge before
      smp_valid = 1'b0;
      pending = 1'b1;
   endtask

   task automatic wait_settled();
      if (pending) begin
         while (!smp_ready) @(negedge clk_x);
         repeat (4) @(negedge clk_x);      // Last write lands after the slot sweep
         pending = 1'b0;
      end
   endtask

   task automatic axi_read(input logic [7:0] addr, output vis_word_u data,
                           output logic [1:0] resp);
      araddr = addr;
      arvalid = 1'b1;
      while (!arready) @(negedge clk_x);
      @(negedge clk_x);
      arvalid = 1'b0;
      while (!rvalid) @(negedge clk_x);
      repeat ($urandom_range(3, 0)) @(negedge clk_x);   // Host stalls R
      data.raw = rdata;
      resp = rresp;
      rready = 1'b1;
      @(negedge clk_x);
      rready = 1'b0;
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
      awaddr = addr;
      wdata = data;
      wstrb = 4'hf;
      awvalid = 1'b1;
      wvalid = 1'b1;
      while (!(awready && wready)) @(negedge clk_x);
      @(negedge clk_x);
      awvalid = 1'b0;
      wvalid = 1'b0;
      while (!bvalid) @(negedge clk_x);
      repeat ($urandom_range(3, 0)) @(negedge clk_x);   // Host stalls B
      check_resp(bresp, OKAY, $sformatf("write to 0x%h", addr));
      bready = 1'b1;
      @(negedge clk_x);
      bready = 1'b0;
   endtask

   task automatic verify_pair(input logic [SLOT_W-1:0] pair, input vis_t exp_vis);
      vis_word_u got, exp;
      logic [1:0] resp;
      wait_settled();
      axi_read({2'b00, pair, 2'b00}, got, resp);
      exp.vis = exp_vis;
      check_resp(resp, OKAY, $sformatf("read of pair %0d", pair));
      check_vis(got, exp, $sformatf("pair %0d", pair));
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      int n_smp, n_rd;
      vis_word_u got, zero_word;
      logic [1:0] resp;
      void'($urandom(32'h18aaef59));
      rst_n = 1'b0;
      smp = '0;
      {smp_valid, awvalid, wvalid, bready, arvalid, rready} = '0;
      {awaddr, araddr, wdata, wstrb} = '0;
      pending = 1'b0;
      load_testdata();
      n_smp = 0;
      n_rd = (16 - NUM_PAIRS) + 3 + NUM_PAIRS;   // Range, write and re-read passes
      foreach (recs[i]) begin
         if (recs[i].kind == "S") n_smp++;
         else n_rd++;
      end
      limit = n_smp * (NUM_PAIRS + 4) + n_rd * 12 + 200;
      repeat (4) @(negedge clk_x);
      rst_n = 1'b1;
      @(negedge clk_x);
      foreach (recs[i]) begin
         if (recs[i].kind == "S") begin
            send_sample(recs[i].smp);
         end else begin
            last_vis[recs[i].pair] = recs[i].vis;
            verify_pair(recs[i].pair, recs[i].vis);
         end
      end
      // Words past the pair table
      zero_word.raw = '0;
      for (int k = NUM_PAIRS; k < 16; k++) begin
         axi_read(8'(k * 4), got, resp);
         check_resp(resp, SLVERR, $sformatf("read of word %0d", k));
         check_vis(got, zero_word, $sformatf("word %0d", k));
      end
      axi_write(8'h00, 32'hdeadbeef);
      axi_write(8'h14, 32'h0000ffff);
      axi_write(8'h3c, 32'h12345678);
      for (int k = 0; k < NUM_PAIRS; k++) begin
         verify_pair(SLOT_W'(k), last_vis[k]);   // Writes left the counts alone
      end
      if (assert_errors() == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/corr_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module corr_assertions #(
   parameter int NUM_PAIRS = 12            // Slots per sample
) (
   input logic        clk_x,
   input logic        rst_n,
   input logic        rvalid,
   input logic        rready,
   input logic [31:0] rdata,
   input logic        bvalid,
   input logic        bready,
   input logic        smp_valid,
   input logic        smp_ready
);

   int err_cnt;                            // Failed assertions so far

   // --------------------------------------------------
   // AXI4-Lite response channels
   // --------------------------------------------------
   rvalid_hold: assert property (@(posedge clk_x) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else begin
         err_cnt++;
         $error("rvalid dropped or rdata changed while rready was low");
      end

   bvalid_hold: assert property (@(posedge clk_x) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
      else begin
         err_cnt++;
         $error("bvalid dropped while bready was low");
      end

   // One slot per pair and then ready again
   smp_busy: assert property (@(posedge clk_x) disable iff (!rst_n)
      smp_valid && smp_ready |=> !smp_ready [*NUM_PAIRS] ##1 smp_ready)
      else begin
         err_cnt++;
         $error("smp_ready was not low for exactly NUM_PAIRS cycles");
      end

endmodule

// Read side of the bus slave with the sample port tied idle
bind vis_axil_reader corr_assertions #(.NUM_PAIRS(NUM_PAIRS)) axil_chk_i (
   .clk_x, .rst_n, .rvalid, .rready, .rdata, .bvalid, .bready,
   .smp_valid(1'b0), .smp_ready(1'b1)
);

// Sample handshake of the sequencer with the bus side tied idle
bind corr_sequencer corr_assertions #(.NUM_PAIRS(NUM_PAIRS)) seq_chk_i (
   .clk_x, .rst_n, .rvalid(1'b0), .rready(1'b1), .rdata(32'h0),
   .bvalid(1'b0), .bready(1'b1), .smp_valid, .smp_ready
);

`default_nettype wire

// File: hdl/corr_top.sv
`timescale 1ns/10ps
`default_nettype none

module corr_top import corr_pkg::*; #(
   parameter int                     NUM_PAIRS  = 12,
   // Pairs {b, a} in octal, pair 0 in the low digits
   parameter logic [NUM_PAIRS*6-1:0] PAIR_TABLE = 72'o767565746454323121302010
) (
   input  logic        clk_x,
   input  logic        rst_n,
   // Sample input
   input  sample_t     smp,
   input  logic        smp_valid,
   output logic        smp_ready,
   // AXI4-Lite slave
   input  logic [7:0]  awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [7:0]  araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready
);

   slot_req_t         req;
   logic              req_valid;
   sample_t           smp_hold;
   corr_bits_t        bits;
   logic              bits_valid;
   logic              bank;                // Active bank
   logic              rd_en;
   logic [SLOT_W-1:0] rd_slot;
   vis_word_u         rd_data;

   // --------------------------------------------------
   // Correlation pipeline
   // --------------------------------------------------
   corr_sequencer #(.NUM_PAIRS(NUM_PAIRS)) seq_i (
      .clk_x, .rst_n, .smp, .smp_valid, .smp_ready,
      .req, .req_valid, .bank, .smp_hold
   );

   corr_pair_select #(.NUM_PAIRS(NUM_PAIRS), .PAIR_TABLE(PAIR_TABLE)) sel_i (
      .clk_x, .rst_n, .req, .req_valid, .smp_hold, .bits, .bits_valid
   );

   corr_accumulate #(.NUM_PAIRS(NUM_PAIRS)) acc_i (
      .clk_x, .rst_n, .bits, .bits_valid, .bank, .rd_en, .rd_slot, .rd_data
   );

   // Bus side reads the inactive bank
   vis_axil_reader #(.NUM_PAIRS(NUM_PAIRS)) axil_i (
      .clk_x, .rst_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .rd_en, .rd_slot, .rd_data
   );

endmodule

`default_nettype wire

// File: hdl/vis_axil_reader.sv
`timescale 1ns/10ps
`default_nettype none

module vis_axil_reader import corr_pkg::*; #(
   parameter int NUM_PAIRS = 12
) (
   input  logic              clk_x,
   input  logic              rst_n,
   // Write channels, acknowledged only
   input  logic [7:0]        awaddr,
   input  logic              awvalid,
   output logic              awready,
   input  logic [31:0]       wdata,
   input  logic [3:0]        wstrb,
   input  logic              wvalid,
   output logic              wready,
   output logic [1:0]        bresp,
   output logic              bvalid,
   input  logic              bready,
   // Read channels
   input  logic [7:0]        araddr,
   input  logic              arvalid,
   output logic              arready,
   output logic [31:0]       rdata,
   output logic [1:0]        rresp,
   output logic              rvalid,
   input  logic              rready,
   // Accumulator read port
   output logic              rd_en,
   output logic [SLOT_W-1:0] rd_slot,
   input  vis_word_u         rd_data
);

   localparam logic [1:0] RD_IDLE  = 2'd0;
   localparam logic [1:0] RD_FETCH = 2'd1; // RAM read issued
   localparam logic [1:0] RD_WAIT  = 2'd2; // RAM data arrives
   localparam logic [1:0] RD_RESP  = 2'd3; // Hold R channel

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic [1:0]        rd_state;
   logic [SLOT_W-1:0] word_idx;            // araddr[5:2]
   logic              idx_ok;              // Word index names a pair
   logic              aw_seen;             // AW taken, W pending
   logic              w_seen;              // W taken, AW pending
   logic              aw_got;
   logic              w_got;

   // --------------------------------------------------
   // Read FSM
   // --------------------------------------------------
   assign arready = (rd_state == RD_IDLE);
   assign rvalid  = (rd_state == RD_RESP);
   assign rd_en   = (rd_state == RD_FETCH) && idx_ok;
   assign rd_slot = word_idx;

   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         rd_state <= RD_IDLE;
      end else begin
         case (rd_state)
            RD_IDLE:  if (arvalid) rd_state <= RD_FETCH;
            RD_FETCH: rd_state <= RD_WAIT;
            RD_WAIT:  rd_state <= RD_RESP;
            default:  if (rready) rd_state <= RD_IDLE;   // Next AR one cycle later
         endcase
      end
   end

   always_ff @(posedge clk_x) begin
      if (arvalid && arready) begin
         word_idx <= araddr[5:2];
         idx_ok   <= (araddr[5:2] < NUM_PAIRS);
      end
      if (rd_state == RD_WAIT) begin
         rdata <= idx_ok ? rd_data.raw : '0;            // Zero on SLVERR
         rresp <= idx_ok ? RESP_OKAY : RESP_SLVERR;
      end
   end

   // --------------------------------------------------
   // Write responder, data dropped
   // --------------------------------------------------
   assign awready = !aw_seen && !bvalid;
   assign wready  = !w_seen && !bvalid;
   assign aw_got  = aw_seen || (awvalid && awready);
   assign w_got   = w_seen || (wvalid && wready);
   assign bresp   = RESP_OKAY;

   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         aw_seen <= 1'b0;
         w_seen  <= 1'b0;
         bvalid  <= 1'b0;
      end else if (bvalid) begin
         if (bready) bvalid <= 1'b0;
      end else if (aw_got && w_got) begin
         bvalid  <= 1'b1;                  // Response one cycle after both
         aw_seen <= 1'b0;
         w_seen  <= 1'b0;
      end else begin
         aw_seen <= aw_got;                // Wait for the other channel
         w_seen  <= w_got;
      end
   end

endmodule

`default_nettype wire

// File: hdl/corr_accumulate.sv
`timescale 1ns/10ps
`default_nettype none

module corr_accumulate import corr_pkg::*; #(
   parameter int NUM_PAIRS = 12
) (
   input  logic              clk_x,
   input  logic              rst_n,
   input  corr_bits_t        bits,         // From pair select
   input  logic              bits_valid,
   input  logic              bank,         // Active bank
   input  logic              rd_en,        // Bus read strobe
   input  logic [SLOT_W-1:0] rd_slot,
   output vis_word_u         rd_data       // One cycle after rd_en
);

   // Two banks of NUM_PAIRS counters, no reset on contents
   vis_t acc_mem [2][NUM_PAIRS];

   corr_bits_t s1_bits;                    // Slot in the add stage
   logic       s1_valid;
   vis_t       s1_acc;                     // Old count or zero
   vis_t       s2_sum;                     // Updated count

   // --------------------------------------------------
   // Stage 1 reads the current entry
   // --------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= bits_valid;
      end
   end

   always_ff @(posedge clk_x) begin
      if (bits_valid) begin
         s1_bits <= bits;
         if (bits.req.clr) begin
            s1_acc <= '0;                  // New integration starts from zero
         end else begin
            s1_acc <= acc_mem[bits.req.bank][bits.req.slot];
         end
      end
   end

   // --------------------------------------------------
   // Stage 2 adds the agreement bits
   // --------------------------------------------------
   always_comb begin
      // Cosine term counts re[a] == re[b]
      s2_sum.cos_cnt = s1_acc.cos_cnt + ACC_W'(s1_bits.ar == s1_bits.br);
      // Sine term counts re[a] == im[b]
      s2_sum.sin_cnt = s1_acc.sin_cnt + ACC_W'(s1_bits.ar == s1_bits.bi);
   end

   // Write back and bus read port
   always_ff @(posedge clk_x) begin
      if (s1_valid) begin
         acc_mem[s1_bits.req.bank][s1_bits.req.slot] <= s2_sum;  // Bank from the slot
      end
      if (rd_en) begin
         rd_data.vis <= acc_mem[~bank][rd_slot];   // Finished integration
      end
   end

endmodule

`default_nettype wire

// File: hdl/corr_pair_select.sv
`timescale 1ns/10ps
`default_nettype none

module corr_pair_select import corr_pkg::*; #(
   parameter int                     NUM_PAIRS  = 12,
   parameter logic [NUM_PAIRS*6-1:0] PAIR_TABLE = '0    // Set from the top level
) (
   input  logic       clk_x,
   input  logic       rst_n,
   input  slot_req_t  req,
   input  logic       req_valid,
   input  sample_t    smp_hold,            // Held sample bits
   output corr_bits_t bits,
   output logic       bits_valid
);

   localparam int ENT_W = 2 * ANT_W;       // One table entry, {b, a}

   logic [ENT_W-1:0] entry;
   logic [ANT_W-1:0] a_idx;
   logic [ANT_W-1:0] b_idx;

   // --------------------------------------------------
   // Pair table lookup
   // --------------------------------------------------
   assign entry = PAIR_TABLE[req.slot*ENT_W +: ENT_W];    // Pair 0 in the low bits
   assign b_idx = entry[ENT_W-1:ANT_W];
   assign a_idx = entry[ANT_W-1:0];

   // Valid follows the request by one cycle
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         bits_valid <= 1'b0;
      end else begin
         bits_valid <= req_valid;
      end
   end

   // Pick out the three bits the accumulator needs
   always_ff @(posedge clk_x) begin
      bits.req <= req;                     // Slot, bank, clr travel along
      bits.ar  <= smp_hold.re[a_idx];
      bits.br  <= smp_hold.re[b_idx];
      bits.bi  <= smp_hold.im[b_idx];
   end

endmodule

`default_nettype wire

// File: hdl/corr_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module corr_sequencer import corr_pkg::*; #(
   parameter int NUM_PAIRS = 12            // Slots per sample
) (
   input  logic      clk_x,
   input  logic      rst_n,
   input  sample_t   smp,                  // Sample from the front end
   input  logic      smp_valid,
   output logic      smp_ready,
   output slot_req_t req,                  // Slot request to pair select
   output logic      req_valid,
   output logic      bank,                 // Active bank
   output sample_t   smp_hold              // Latched sample for pair select
);

   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_PAIRS - 1);

   logic              busy;                // Slots of a sample being issued
   logic [SLOT_W-1:0] slot_q;              // Slot issued this cycle
   logic              bank_q;
   logic              take;                // Sample handshake

   assign take      = smp_valid && !busy;
   assign smp_ready = !busy;               // Idle means ready
   assign req_valid = busy;
   assign bank      = bank_q;

   // --------------------------------------------------
   // Slot counter and bank register
   // --------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         busy   <= 1'b0;
         slot_q <= '0;
         bank_q <= 1'b0;                   // Start in bank 0
      end else if (take) begin
         busy   <= 1'b1;                   // First slot issues next cycle
         slot_q <= '0;
         bank_q <= bank_q ^ smp.sw;        // Toggle at acceptance
      end else if (busy) begin
         if (slot_q == LAST_SLOT) begin
            busy <= 1'b0;                  // Ready again after NUM_PAIRS slots
         end
         slot_q <= slot_q + 1'b1;
      end
   end

   // Sample bits held for the whole slot sweep
   always_ff @(posedge clk_x) begin
      if (take) begin
         smp_hold <= smp;
      end
   end

   // The switch flag of the held sample clears every slot it touches
   assign req = '{slot: slot_q, bank: bank_q, clr: smp_hold.sw};

endmodule

`default_nettype wire

// File: hdl/corr_pkg.sv
`default_nettype none

package corr_pkg;

   // --------------------------------------------------
   // Array size and widths
   // --------------------------------------------------
   localparam int NUM_ANT = 8;             // Antennas per sample
   localparam int ANT_W   = 3;             // Antenna index bits
   localparam int SLOT_W  = 4;             // Slot index bits, up to 16 pairs
   localparam int ACC_W   = 16;            // Per-pair counter width, wraps

   // One accepted sample from the 1-bit front end
   typedef struct packed {
      logic [NUM_ANT-1:0] re;              // Real sign bit per antenna
      logic [NUM_ANT-1:0] im;              // Imaginary sign bit per antenna
      logic               sw;              // Switch banks with this sample
   } sample_t;

   // Sequencer output, one per time slot
   typedef struct packed {
      logic [SLOT_W-1:0] slot;             // Pair number
      logic              bank;             // Bank the slot accumulates into
      logic              clr;              // First access after a switch
   } slot_req_t;

   // Pair select output
   typedef struct packed {
      slot_req_t req;                      // Slot control carried along
      logic      ar;                       // re[a]
      logic      br;                       // re[b]
      logic      bi;                       // im[b]
   } corr_bits_t;

   // One stored visibility
   typedef struct packed {
      logic [ACC_W-1:0] sin_cnt;           // Upper half
      logic [ACC_W-1:0] cos_cnt;           // Lower half
   } vis_t;

   // Readout word, seen as counters or as a bus word
   typedef union packed {
      vis_t               vis;
      logic [2*ACC_W-1:0] raw;
   } vis_word_u;

endpackage

`default_nettype wire
